// ==== core_top.f ====
source/core_pkg.sv
source/core_regfile.sv
source/core_decode.sv
source/core_execute.sv
source/core_csr.sv
source/core_result.sv
source/core_trace.sv
source/core_top.sv
dv/core_tb.sv

// ==== dv/core_tb.sv ====
module core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import core_pkg::*;

    localparam int          PROG_LEN   = 200;
    localparam int          CLK_PERIOD = 20;
    localparam logic [31:0] BOOT_ADDR  = 32'h0000_0100;
    localparam logic [31:0] HART_ID    = 32'h0000_0005;
    // ADDI x0, x0, 0
    localparam logic [31:0] NOP        = 32'h0000_0013;

    logic        clk = 1'b0;
    logic        arst_n;
    logic [31:0] hartid;
    logic [31:0] boot_addr;
    logic [31:0] imem_rdata;
    logic [31:0] imem_addr;
    trace_t      trace;

    integer      seed = 2;
    int          retired;
    logic [31:0] prog [PROG_LEN];

    // Reference architectural state
    logic [31:0] m_regs [32];
    logic [31:0] m_mscratch;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;
    logic [31:0] m_pc;
    logic [63:0] m_order;

    core_top #(.ISA_M(1'b1)) u_dut (
        .clk_i        ( clk ),
        .arst_n_i     ( arst_n ),
        .hartid_i     ( hartid ),
        .boot_addr_i  ( boot_addr ),
        .imem_rdata_i ( imem_rdata ),
        .imem_addr_o  ( imem_addr ),
        .trace_o      ( trace )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] rand_bits();
        return $random(seed);
    endfunction

    function automatic logic [31:0] r_format(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                             logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_format(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                             logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // Registers limited to x0..x7 so that dependencies are frequent
    function automatic logic [31:0] random_insn(int kind);
        logic [31:0] rnd;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        rnd = rand_bits();
        rd  = 5'(rand_bits() % 8);
        rs1 = 5'(rand_bits() % 8);
        rs2 = 5'(rand_bits() % 8);
        f3  = rnd[2:0];
        case (kind)
            0, 1: begin
                f7 = 7'h00;
                if (rnd[3] && (f3 == 3'd0 || f3 == 3'd5)) begin
                    f7 = 7'h20;
                end
                if (rnd[6:4] == 3'd0) begin
                    f7 = 7'h01;
                    f3 = 3'd0;
                end
                return r_format(f7, rs2, rs1, f3, rd, 7'h33);
            end
            2, 3: begin
                imm = rnd[31:20];
                if (f3 == 3'd1) begin
                    imm[11:5] = 7'h00;
                end
                if (f3 == 3'd5) begin
                    imm[11:5] = rnd[3] ? 7'h20 : 7'h00;
                end
                return i_format(imm, rs1, f3, rd, 7'h13);
            end
            4: return {rnd[31:12], rd, 7'h37};
            5, 6: begin
                // Mostly mscratch with 0x7C0 as the unimplemented address
                case (rnd[6:4])
                    3'd0:    imm = CSR_MISA;
                    3'd1:    imm = CSR_MHARTID;
                    3'd2:    imm = CSR_MEPC;
                    3'd3:    imm = CSR_MCAUSE;
                    3'd4:    imm = 12'h7C0;
                    default: imm = CSR_MSCRATCH;
                endcase
                f3 = 3'd1 + 3'(rnd[9:8] % 3);
                return i_format(imm, rs1, f3, rd, 7'h73);
            end
            default: begin
                case (rnd[5:4])
                    2'd0:    return i_format(rnd[31:20], rs1, f3, rd, 7'h03);
                    2'd1:    return r_format(7'h15, rs2, rs1, f3, rd, 7'h33);
                    2'd2:    return r_format(7'h01, rs2, rs1, f3 | 3'd1, rd, 7'h33);
                    default: return i_format(12'h000, 5'd0, 3'd0, 5'd0, 7'h73);
                endcase
            end
        endcase
    endfunction

    function automatic logic [31:0] fetch_word(logic [31:0] addr);
        logic [31:0] off;
        off = addr - BOOT_ADDR;
        if (off[1:0] == 2'b00 && off < 32'(PROG_LEN * 4)) begin
            return prog[off >> 2];
        end
        return NOP;
    endfunction

    // Executes one instruction on the reference state and returns the expected trace
    function automatic trace_t model_step(logic [31:0] insn);
        trace_t      want;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [11:0] csr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic [31:0] old;
        logic        legal;
        f7    = insn[31:25];
        f3    = insn[14:12];
        rd    = insn[11:7];
        csr   = insn[31:20];
        a     = m_regs[insn[19:15]];
        b     = m_regs[insn[24:20]];
        imm   = {{20{insn[31]}}, insn[31:20]};
        res   = '0;
        old   = '0;
        legal = 1'b1;
        want  = '0;
        case (insn[6:0])
            7'h33: begin
                case ({f7, f3})
                    {7'h00, 3'd0}: res = a + b;
                    {7'h20, 3'd0}: res = a - b;
                    {7'h00, 3'd1}: res = a << b[4:0];
                    {7'h00, 3'd2}: res = 32'($signed(a) < $signed(b));
                    {7'h00, 3'd3}: res = 32'(a < b);
                    {7'h00, 3'd4}: res = a ^ b;
                    {7'h00, 3'd5}: res = a >> b[4:0];
                    {7'h20, 3'd5}: res = $signed(a) >>> b[4:0];
                    {7'h00, 3'd6}: res = a | b;
                    {7'h00, 3'd7}: res = a & b;
                    {7'h01, 3'd0}: res = a * b;
                    default:       legal = 1'b0;
                endcase
            end
            7'h13: begin
                case (f3)
                    3'd0: res = a + imm;
                    3'd1: begin
                        res   = a << imm[4:0];
                        legal = (f7 == 7'h00);
                    end
                    3'd2: res = 32'($signed(a) < $signed(imm));
                    3'd3: res = 32'(a < imm);
                    3'd4: res = a ^ imm;
                    3'd5: begin
                        if (f7 == 7'h20) begin
                            res = $signed(a) >>> imm[4:0];
                        end else begin
                            res = a >> imm[4:0];
                        end
                        legal = (f7 == 7'h00) || (f7 == 7'h20);
                    end
                    3'd6: res = a | imm;
                    default: res = a & imm;
                endcase
            end
            7'h37: res = {insn[31:12], 12'h000};
            7'h73: begin
                // MXL=1 with the I and M extensions
                case (csr)
                    CSR_MISA:     old = 32'h4000_1100;
                    CSR_MHARTID:  old = HART_ID;
                    CSR_MSCRATCH: old = m_mscratch;
                    CSR_MEPC:     old = m_mepc;
                    CSR_MCAUSE:   old = m_mcause;
                    default:      legal = 1'b0;
                endcase
                if (f3 == 3'd0 || f3 > 3'd3) begin
                    legal = 1'b0;
                end
                res = old;
                if (legal) begin
                    want.csr_addr  = csr;
                    want.csr_wdata = (f3 == 3'd1) ? a : (f3 == 3'd2) ? (old | a) : (old & ~a);
                    want.csr_wb    = (csr == CSR_MSCRATCH) || (csr == CSR_MEPC)
                                     || (csr == CSR_MCAUSE);
                    case (csr)
                        CSR_MSCRATCH: m_mscratch = want.csr_wdata;
                        CSR_MEPC:     m_mepc     = want.csr_wdata;
                        CSR_MCAUSE:   m_mcause   = want.csr_wdata;
                        default:      ;
                    endcase
                end
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            want.trap = 1'b1;
            m_mepc    = m_pc;
            m_mcause  = 32'd2;
        end else if (rd != 5'd0) begin
            m_regs[rd]        = res;
            want.x_wb[rd]     = 1'b1;
            want.x_wdata[rd]  = res;
        end
        want.valid    = 1'b1;
        want.order    = m_order;
        want.insn     = insn;
        want.pc_rdata = m_pc;
        want.pc_wdata = m_pc + 32'd4;
        m_pc          = m_pc + 32'd4;
        m_order       = m_order + 64'd1;
        return want;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Instruction port answers for the current fetch address
    always @(posedge clk) begin
        #1;
        imem_rdata = fetch_word(imem_addr);
    end

    // Trace sampled mid-cycle away from the clock edge
    always @(negedge clk) begin : compare
        trace_t      want;
        logic [4:0]  rd;
        if (!arst_n) begin
            check_value("trace_o.valid", 64'd0, trace.valid);
        end
        if (!trace.valid) begin
            check_value("trace_o.x_wb", 64'd0, trace.x_wb);
            if (retired > 0 && retired < PROG_LEN) begin
                check_value("trace_o.valid", 64'd1, trace.valid);
            end
        end else if (retired < PROG_LEN) begin
            want = model_step(prog[retired]);
            rd   = prog[retired][11:7];
            check_value("trace_o.order", want.order, trace.order);
            check_value("trace_o.insn", want.insn, trace.insn);
            check_value("trace_o.pc_rdata", want.pc_rdata, trace.pc_rdata);
            check_value("trace_o.pc_wdata", want.pc_wdata, trace.pc_wdata);
            check_value("trace_o.trap", want.trap, trace.trap);
            check_value("trace_o.x_wb", want.x_wb, trace.x_wb);
            if (want.x_wb != 32'd0) begin
                check_value("trace_o.x_wdata", want.x_wdata[rd], trace.x_wdata[rd]);
            end
            check_value("trace_o.csr_wb", want.csr_wb, trace.csr_wb);
            if (want.csr_wb) begin
                check_value("trace_o.csr_addr", want.csr_addr, trace.csr_addr);
                check_value("trace_o.csr_wdata", want.csr_wdata, trace.csr_wdata);
            end
            retired++;
        end
    end

    initial begin : stimulus
        int idx;
        int kind;
        arst_n     = 1'b1;
        hartid     = HART_ID;
        boot_addr  = BOOT_ADDR;
        imem_rdata = NOP;
        retired    = 0;
        m_pc       = BOOT_ADDR;
        m_order    = '0;
        m_mscratch = '0;
        m_mepc     = '0;
        m_mcause   = '0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        // An illegal encoding is followed by reads of mepc and mcause
        idx = 0;
        while (idx < PROG_LEN) begin
            kind      = rand_bits() % 8;
            prog[idx] = random_insn(kind);
            idx++;
            if (kind == 7 && idx <= PROG_LEN - 2) begin
                prog[idx] = i_format(CSR_MEPC, 5'd0, 3'd2, 5'd1, 7'h73);
                idx++;
                prog[idx] = i_format(CSR_MCAUSE, 5'd0, 3'd2, 5'd2, 7'h73);
                idx++;
            end
        end
        #1;
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        wait (retired == PROG_LEN);
        $display("test passed");
        $finish;
    end

    initial begin : watchdog
        #((PROG_LEN + 20) * CLK_PERIOD);
        $display("Timeout, retirements stopped after %0d of %0d", retired, PROG_LEN);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== source/core_csr.sv ====
module core_csr #(
    parameter bit ISA_M = 1'b0
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic [core_pkg::XLEN-1:0] hartid_i,
    input  logic [11:0]               rd_addr_i,
    input  core_pkg::csr_op_e         rd_op_i,
    input  core_pkg::exe_t            commit_i,
    output logic [core_pkg::XLEN-1:0] rdata_o,
    output logic                      illegal_o
);
    import core_pkg::*;

    // RV32 with I, plus M when the multiplier is built
    localparam logic [XLEN-1:0] MISA_VAL = 32'h4000_0100 | (XLEN'(ISA_M) << 12);

    logic [XLEN-1:0] mscratch_q, mscratch_d;
    logic [XLEN-1:0] mepc_q, mepc_d;
    logic [XLEN-1:0] mcause_q, mcause_d;

    always_comb begin
        logic [XLEN-1:0] wval;
        wval       = csr_apply(commit_i.csr_op, commit_i.result, commit_i.csr_operand);
        mscratch_d = mscratch_q;
        mepc_d     = mepc_q;
        mcause_d   = mcause_q;
        if (commit_i.valid && commit_i.illegal) begin
            mepc_d   = commit_i.pc;
            mcause_d = CAUSE_ILLEGAL;
        end else if (commit_i.valid && commit_i.csr_op != CSR_OP_NONE) begin
            case (commit_i.csr_addr)
                CSR_MSCRATCH: mscratch_d = wval;
                CSR_MEPC:     mepc_d     = wval;
                CSR_MCAUSE:   mcause_d   = wval;
                default:      ;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else begin
            mscratch_q <= mscratch_d;
            mepc_q     <= mepc_d;
            mcause_q   <= mcause_d;
        end
    end

    // Reads see the commit of the instruction one ahead
    always_comb begin
        rdata_o   = '0;
        illegal_o = 1'b0;
        case (rd_addr_i)
            CSR_MISA:     rdata_o = MISA_VAL;
            CSR_MHARTID:  rdata_o = hartid_i;
            CSR_MSCRATCH: rdata_o = mscratch_d;
            CSR_MEPC:     rdata_o = mepc_d;
            CSR_MCAUSE:   rdata_o = mcause_d;
            default:      illegal_o = (rd_op_i != CSR_OP_NONE);
        endcase
    end

endmodule

// ==== source/core_decode.sv ====
module core_decode #(
    parameter bit ISA_M = 1'b0
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic [core_pkg::XLEN-1:0] boot_addr_i,
    input  logic [core_pkg::XLEN-1:0] imem_rdata_i,
    output logic [core_pkg::XLEN-1:0] imem_addr_o,
    output core_pkg::dec_t            dec_o
);
    import core_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    dec_t            dec_d;

    assign funct3      = imem_rdata_i[14:12];
    assign funct7      = imem_rdata_i[31:25];
    assign imem_addr_o = pc_q;

    always_comb begin
        dec_d          = '0;
        dec_d.valid    = 1'b1;
        dec_d.pc       = pc_q;
        dec_d.insn     = imem_rdata_i;
        dec_d.rs1      = imem_rdata_i[19:15];
        dec_d.rs2      = imem_rdata_i[24:20];
        dec_d.rd       = imem_rdata_i[11:7];
        dec_d.imm      = {{20{imem_rdata_i[31]}}, imem_rdata_i[31:20]};
        dec_d.csr_addr = imem_rdata_i[31:20];
        dec_d.alu_op   = ALU_ADD;
        dec_d.csr_op   = CSR_OP_NONE;
        dec_d.rd_we    = 1'b1;
        case (imem_rdata_i[6:0])
            OPC_OP: begin
                case ({funct7, funct3})
                    {7'h00, 3'b000}: dec_d.alu_op = ALU_ADD;
                    {7'h20, 3'b000}: dec_d.alu_op = ALU_SUB;
                    {7'h00, 3'b001}: dec_d.alu_op = ALU_SLL;
                    {7'h00, 3'b010}: dec_d.alu_op = ALU_SLT;
                    {7'h00, 3'b011}: dec_d.alu_op = ALU_SLTU;
                    {7'h00, 3'b100}: dec_d.alu_op = ALU_XOR;
                    {7'h00, 3'b101}: dec_d.alu_op = ALU_SRL;
                    {7'h20, 3'b101}: dec_d.alu_op = ALU_SRA;
                    {7'h00, 3'b110}: dec_d.alu_op = ALU_OR;
                    {7'h00, 3'b111}: dec_d.alu_op = ALU_AND;
                    {7'h01, 3'b000}: begin
                        dec_d.alu_op  = ALU_MUL;
                        dec_d.illegal = !ISA_M;
                    end
                    default: dec_d.illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                dec_d.use_imm = 1'b1;
                case (funct3)
                    3'b000: dec_d.alu_op = ALU_ADD;
                    3'b010: dec_d.alu_op = ALU_SLT;
                    3'b011: dec_d.alu_op = ALU_SLTU;
                    3'b100: dec_d.alu_op = ALU_XOR;
                    3'b110: dec_d.alu_op = ALU_OR;
                    3'b111: dec_d.alu_op = ALU_AND;
                    3'b001: begin
                        dec_d.alu_op  = ALU_SLL;
                        dec_d.illegal = (funct7 != 7'h00);
                    end
                    default: begin
                        // Shift right, funct7 picks logical or arithmetic
                        dec_d.alu_op  = funct7[5] ? ALU_SRA : ALU_SRL;
                        dec_d.illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
                    end
                endcase
            end
            OPC_LUI: begin
                dec_d.use_imm = 1'b1;
                dec_d.imm     = {imem_rdata_i[31:12], 12'h000};
                dec_d.alu_op  = ALU_PASS_B;
            end
            OPC_SYSTEM: begin
                case (funct3)
                    3'b001:  dec_d.csr_op = CSR_OP_RW;
                    3'b010:  dec_d.csr_op = CSR_OP_RS;
                    3'b011:  dec_d.csr_op = CSR_OP_RC;
                    default: dec_d.illegal = 1'b1;
                endcase
            end
            default: dec_d.illegal = 1'b1;
        endcase
        if (dec_d.illegal) begin
            dec_d.rd_we  = 1'b0;
            dec_d.csr_op = CSR_OP_NONE;
        end
    end

    // No branches, so the fetch address only steps forward
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q  <= boot_addr_i;
            dec_o <= '0;
        end else begin
            pc_q  <= pc_q + 32'd4;
            dec_o <= dec_d;
        end
    end

endmodule

// ==== source/core_execute.sv ====
module core_execute #(
    parameter bit ISA_M = 1'b0
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  core_pkg::dec_t            dec_i,
    input  logic [core_pkg::XLEN-1:0] rs1_data_i,
    input  logic [core_pkg::XLEN-1:0] rs2_data_i,
    input  core_pkg::retire_t         byp_i,
    input  logic [core_pkg::XLEN-1:0] csr_rdata_i,
    input  logic                      csr_illegal_i,
    output logic [4:0]                rs1_addr_o,
    output logic [4:0]                rs2_addr_o,
    output logic [11:0]               csr_addr_o,
    output core_pkg::csr_op_e         csr_op_o,
    output core_pkg::exe_t            exe_o
);
    import core_pkg::*;

    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] mul_res;
    logic [XLEN-1:0] alu_res;
    exe_t            exe_d;

    assign rs1_addr_o = dec_i.rs1;
    assign rs2_addr_o = dec_i.rs2;
    assign csr_addr_o = dec_i.csr_addr;
    assign csr_op_o   = dec_i.valid ? dec_i.csr_op : CSR_OP_NONE;

    // Register file holds the result two ahead and forwards the one directly ahead
    assign op_b = dec_i.use_imm ? dec_i.imm : rs2_data_i;

    generate
        if (ISA_M) begin : g_mul
            assign mul_res = rs1_data_i * op_b;
        end else begin : g_no_mul
            assign mul_res = '0;
        end
    endgenerate

    always_comb begin
        case (dec_i.alu_op)
            ALU_SUB:    alu_res = rs1_data_i - op_b;
            ALU_SLL:    alu_res = rs1_data_i << op_b[4:0];
            ALU_SLT:    alu_res = XLEN'($signed(rs1_data_i) < $signed(op_b));
            ALU_SLTU:   alu_res = XLEN'(rs1_data_i < op_b);
            ALU_XOR:    alu_res = rs1_data_i ^ op_b;
            ALU_SRL:    alu_res = rs1_data_i >> op_b[4:0];
            ALU_SRA:    alu_res = $signed(rs1_data_i) >>> op_b[4:0];
            ALU_OR:     alu_res = rs1_data_i | op_b;
            ALU_AND:    alu_res = rs1_data_i & op_b;
            ALU_MUL:    alu_res = mul_res;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = rs1_data_i + op_b;
        endcase
    end

    always_comb begin
        exe_d             = '0;
        exe_d.valid       = dec_i.valid;
        exe_d.pc          = dec_i.pc;
        exe_d.insn        = dec_i.insn;
        exe_d.rd          = dec_i.rd;
        exe_d.rd_we       = dec_i.rd_we && !csr_illegal_i;
        exe_d.csr_op      = dec_i.csr_op;
        exe_d.csr_addr    = dec_i.csr_addr;
        exe_d.csr_operand = rs1_data_i;
        exe_d.illegal     = dec_i.illegal || csr_illegal_i;
        // CSR access returns the old value
        exe_d.result      = (dec_i.csr_op != CSR_OP_NONE) ? csr_rdata_i : alu_res;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exe_o <= '0;
        end else begin
            exe_o <= exe_d;
        end
    end

endmodule

// ==== source/core_pkg.sv ====
package core_pkg;

    localparam int XLEN = 32;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_MUL,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        CSR_OP_NONE,
        CSR_OP_RW,
        CSR_OP_RS,
        CSR_OP_RC
    } csr_op_e;

    // Machine CSR addresses
    localparam logic [11:0] CSR_MISA     = 12'h301;
    localparam logic [11:0] CSR_MHARTID  = 12'hF14;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;

    localparam logic [XLEN-1:0] CAUSE_ILLEGAL = 32'd2;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] insn;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic [XLEN-1:0] imm;
        logic            use_imm;
        alu_op_e         alu_op;
        csr_op_e         csr_op;
        logic [11:0]     csr_addr;
        logic            rd_we;
        logic            illegal;
    } dec_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] insn;
        logic [4:0]      rd;
        logic            rd_we;
        logic [XLEN-1:0] result;
        csr_op_e         csr_op;
        logic [11:0]     csr_addr;
        logic [XLEN-1:0] csr_operand;
        logic            illegal;
    } exe_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc_rdata;
        logic [XLEN-1:0] pc_wdata;
        logic [XLEN-1:0] insn;
        logic            trap;
        logic [4:0]      rd_addr;
        logic [XLEN-1:0] rd_wdata;
        logic            csr_we;
        logic [11:0]     csr_addr;
        logic [XLEN-1:0] csr_wdata;
    } retire_t;

    typedef struct packed {
        logic                  valid;
        logic [63:0]           order;
        logic [XLEN-1:0]       insn;
        logic                  trap;
        logic [XLEN-1:0]       pc_rdata;
        logic [XLEN-1:0]       pc_wdata;
        logic [31:0]           x_wb;
        logic [31:0][XLEN-1:0] x_wdata;
        logic                  csr_wb;
        logic [11:0]           csr_addr;
        logic [XLEN-1:0]       csr_wdata;
    } trace_t;

    // New CSR value for a read-modify-write access
    function automatic logic [XLEN-1:0] csr_apply(
        csr_op_e         op,
        logic [XLEN-1:0] old_val,
        logic [XLEN-1:0] operand
    );
        case (op)
            CSR_OP_RW: return operand;
            CSR_OP_RS: return old_val | operand;
            CSR_OP_RC: return old_val & ~operand;
            default:   return old_val;
        endcase
    endfunction

    // misa and mhartid are read-only here
    function automatic logic csr_writable(logic [11:0] addr);
        return (addr == CSR_MSCRATCH) || (addr == CSR_MEPC) || (addr == CSR_MCAUSE);
    endfunction

endpackage

// ==== source/core_regfile.sv ====
module core_regfile (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic [4:0]                rs1_addr_i,
    input  logic [4:0]                rs2_addr_i,
    input  logic                      we_i,
    input  logic [4:0]                waddr_i,
    input  logic [core_pkg::XLEN-1:0] wdata_i,
    output logic [core_pkg::XLEN-1:0] rs1_data_o,
    output logic [core_pkg::XLEN-1:0] rs2_data_o
);
    import core_pkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs_q [1:31];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // Same-cycle write is visible on the read ports
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 :
                        (we_i && waddr_i == rs1_addr_i) ? wdata_i : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 :
                        (we_i && waddr_i == rs2_addr_i) ? wdata_i : regs_q[rs2_addr_i];

endmodule

// ==== source/core_result.sv ====
module core_result (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  core_pkg::exe_t            exe_i,
    output logic                      rf_we_o,
    output logic [4:0]                rf_waddr_o,
    output logic [core_pkg::XLEN-1:0] rf_wdata_o,
    output core_pkg::retire_t         retire_o
);
    import core_pkg::*;

    retire_t retire_d;

    // Trapping instructions and x0 never reach the register file
    assign rf_we_o    = exe_i.valid && exe_i.rd_we && !exe_i.illegal && (exe_i.rd != '0);
    assign rf_waddr_o = exe_i.rd;
    assign rf_wdata_o = exe_i.result;

    always_comb begin
        retire_d           = '0;
        retire_d.valid     = exe_i.valid;
        retire_d.pc_rdata  = exe_i.pc;
        retire_d.pc_wdata  = exe_i.pc + 32'd4;
        retire_d.insn      = exe_i.insn;
        retire_d.trap      = exe_i.valid && exe_i.illegal;
        retire_d.rd_addr   = rf_we_o ? exe_i.rd : 5'd0;
        retire_d.rd_wdata  = rf_we_o ? exe_i.result : '0;
        retire_d.csr_we    = exe_i.valid && !exe_i.illegal && (exe_i.csr_op != CSR_OP_NONE)
                             && csr_writable(exe_i.csr_addr);
        retire_d.csr_addr  = exe_i.csr_addr;
        retire_d.csr_wdata = csr_apply(exe_i.csr_op, exe_i.result, exe_i.csr_operand);
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_o <= '0;
        end else begin
            retire_o <= retire_d;
        end
    end

endmodule

// ==== source/core_top.sv ====
module core_top #(
    parameter bit ISA_M = 1'b0
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic [core_pkg::XLEN-1:0] hartid_i,
    input  logic [core_pkg::XLEN-1:0] boot_addr_i,
    input  logic [core_pkg::XLEN-1:0] imem_rdata_i,
    output logic [core_pkg::XLEN-1:0] imem_addr_o,
    output core_pkg::trace_t          trace_o
);
    import core_pkg::*;

    dec_t            dec;
    exe_t            exe;
    retire_t         retire;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            rf_we;
    logic [4:0]      rf_waddr;
    logic [XLEN-1:0] rf_wdata;
    logic [11:0]     csr_addr;
    csr_op_e         csr_op;
    logic [XLEN-1:0] csr_rdata;
    logic            csr_illegal;

    core_decode #(.ISA_M(ISA_M)) u_decode (
        .clk_i        ( clk_i ),
        .arst_n_i     ( arst_n_i ),
        .boot_addr_i  ( boot_addr_i ),
        .imem_rdata_i ( imem_rdata_i ),
        .imem_addr_o  ( imem_addr_o ),
        .dec_o        ( dec )
    );

    core_execute #(.ISA_M(ISA_M)) u_execute (
        .clk_i         ( clk_i ),
        .arst_n_i      ( arst_n_i ),
        .dec_i         ( dec ),
        .rs1_data_i    ( rs1_data ),
        .rs2_data_i    ( rs2_data ),
        .byp_i         ( retire ),
        .csr_rdata_i   ( csr_rdata ),
        .csr_illegal_i ( csr_illegal ),
        .rs1_addr_o    ( rs1_addr ),
        .rs2_addr_o    ( rs2_addr ),
        .csr_addr_o    ( csr_addr ),
        .csr_op_o      ( csr_op ),
        .exe_o         ( exe )
    );

    core_regfile u_regfile (
        .clk_i      ( clk_i ),
        .arst_n_i   ( arst_n_i ),
        .rs1_addr_i ( rs1_addr ),
        .rs2_addr_i ( rs2_addr ),
        .we_i       ( rf_we ),
        .waddr_i    ( rf_waddr ),
        .wdata_i    ( rf_wdata ),
        .rs1_data_o ( rs1_data ),
        .rs2_data_o ( rs2_data )
    );

    core_csr #(.ISA_M(ISA_M)) u_csr (
        .clk_i     ( clk_i ),
        .arst_n_i  ( arst_n_i ),
        .hartid_i  ( hartid_i ),
        .rd_addr_i ( csr_addr ),
        .rd_op_i   ( csr_op ),
        .commit_i  ( exe ),
        .rdata_o   ( csr_rdata ),
        .illegal_o ( csr_illegal )
    );

    core_result u_result (
        .clk_i      ( clk_i ),
        .arst_n_i   ( arst_n_i ),
        .exe_i      ( exe ),
        .rf_we_o    ( rf_we ),
        .rf_waddr_o ( rf_waddr ),
        .rf_wdata_o ( rf_wdata ),
        .retire_o   ( retire )
    );

    core_trace u_trace (
        .clk_i    ( clk_i ),
        .arst_n_i ( arst_n_i ),
        .retire_i ( retire ),
        .trace_o  ( trace_o )
    );

endmodule

// ==== source/core_trace.sv ====
module core_trace (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  core_pkg::retire_t retire_i,
    output core_pkg::trace_t  trace_o
);
    import core_pkg::*;

    logic [63:0] order_q;
    trace_t      trace_d;

    always_comb begin
        trace_d           = '0;
        trace_d.valid     = retire_i.valid;
        trace_d.order     = order_q;
        trace_d.insn      = retire_i.insn;
        trace_d.trap      = retire_i.trap;
        trace_d.pc_rdata  = retire_i.pc_rdata;
        trace_d.pc_wdata  = retire_i.pc_wdata;
        trace_d.csr_wb    = retire_i.valid && retire_i.csr_we;
        trace_d.csr_addr  = retire_i.csr_addr;
        trace_d.csr_wdata = retire_i.csr_wdata;
        // One-hot flag for the written register
        if (retire_i.valid && retire_i.rd_addr != '0) begin
            trace_d.x_wb[retire_i.rd_addr]    = 1'b1;
            trace_d.x_wdata[retire_i.rd_addr] = retire_i.rd_wdata;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            trace_o <= '0;
            order_q <= '0;
        end else begin
            trace_o <= trace_d;
            if (retire_i.valid) begin
                order_q <= order_q + 64'd1;
            end
        end
    end

endmodule
